/* Bender.yml */
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - src/dcache_cfg_regs.sv
  - dcache/dcache_line_store.sv
  - dcache/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - verif/axi_mem_model.sv
      - verif/dcache_properties.sv
      - verif/tb_dcache_top.sv

/* common/dcache_pkg.sv */
package dcache_pkg;

  localparam int xlen = 32;
  localparam int line_bytes = 16;
  localparam int beats = line_bytes * 8 / xlen;
  localparam int index_w = 4;
  localparam int offset_w = $clog2(line_bytes);
  localparam int tag_w = xlen - index_w - offset_w;

  // requester operations
  localparam logic [1:0] op_access = 2'd0;
  localparam logic [1:0] op_flush = 2'd1;
  localparam logic [1:0] op_invalidate = 2'd2;

  // config register map, word addressed
  localparam logic [1:0] reg_unc_base = 2'd0;
  localparam logic [1:0] reg_unc_limit = 2'd1;
  localparam logic [1:0] reg_hits = 2'd2;
  localparam logic [1:0] reg_misses = 2'd3;

  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic [tag_w-1:0] tag;
      logic [index_w-1:0] index;
      // upper bits pick the word, low two the byte
      logic [offset_w-1:0] offset;
    } fields;
  } addr_u;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen/8-1:0] wstrb;
    logic [1:0] op;
  } cpu_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] addr;
  } cpu_rsp_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [$clog2(beats)-1:0] len;
  } axi_aw_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [$clog2(beats)-1:0] len;
  } axi_ar_t;

  typedef struct packed {
    logic [xlen-1:0] data;
    logic [xlen/8-1:0] strb;
    logic last;
  } axi_w_t;

  typedef struct packed {
    logic [xlen-1:0] data;
    logic last;
  } axi_r_t;

endpackage

/* compile.f */
common/dcache_pkg.sv
src/dcache_cfg_regs.sv
dcache/dcache_line_store.sv
dcache/dcache_ctrl.sv
src/dcache_top.sv
verif/axi_mem_model.sv
verif/dcache_properties.sv
verif/tb_dcache_top.sv

/* dcache/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     i_req_valid,
  input  cpu_req_t                 i_req,
  output logic                     o_req_ready,
  output logic                     o_rsp_valid,
  output cpu_rsp_t                 o_rsp,
  output logic                     o_aw_valid,
  output axi_aw_t                  o_aw,
  input  logic                     i_aw_ready,
  output logic                     o_w_valid,
  output axi_w_t                   o_w,
  input  logic                     i_w_ready,
  input  logic                     i_b_valid,
  output logic                     o_b_ready,
  output logic                     o_ar_valid,
  output axi_ar_t                  o_ar,
  input  logic                     i_ar_ready,
  input  logic                     i_r_valid,
  input  axi_r_t                   i_r,
  output logic                     o_r_ready,
  input  logic [xlen-1:0]          i_unc_base,
  input  logic [xlen-1:0]          i_unc_limit,
  output logic                     o_hit_evt,
  output logic                     o_miss_evt,
  output logic [index_w-1:0]       o_lookup_idx,
  output logic                     o_store_wr,
  output logic [$clog2(beats)-1:0] o_store_word,
  output logic [xlen-1:0]          o_store_data,
  output logic [xlen/8-1:0]        o_store_strb,
  output logic                     o_refill_beat,
  output logic [xlen-1:0]          o_refill_data,
  output logic                     o_refill_last,
  output logic [tag_w-1:0]         o_refill_tag,
  output logic                     o_clean_line,
  output logic                     o_inval_all,
  input  logic                     i_line_valid,
  input  logic                     i_line_dirty,
  input  logic [tag_w-1:0]         i_line_tag,
  input  logic [xlen-1:0]          i_line_word,
  input  logic [xlen-1:0]          i_beat_word
);

  typedef enum logic [2:0] {s_idle, s_aw, s_w, s_b, s_ar, s_r, s_rsp} state_e;

  state_e                   state_q;
  cpu_req_t                 req_q;
  addr_u                    in_a;
  addr_u                    rq_a;
  logic                     unc_q;
  logic                     flush_q;
  logic [index_w-1:0]       walk_q;
  logic [$clog2(beats)-1:0] beat_q;
  logic                     accept;
  logic                     in_access;
  logic                     in_unc;
  logic                     in_hit;
  logic                     line_wb;

  assign in_a.raw = i_req.addr;
  assign rq_a.raw = req_q.addr;

  // classify the incoming request
  assign o_req_ready = (state_q == s_idle);
  assign accept = i_req_valid && o_req_ready;
  assign in_access = (i_req.op == op_access);
  assign in_unc = in_access && (i_req.addr >= i_unc_base) && (i_req.addr < i_unc_limit);
  assign in_hit = i_line_valid && (i_line_tag == in_a.fields.tag);
  assign line_wb = i_line_valid && i_line_dirty;
  assign o_hit_evt = accept && in_access && !in_unc && in_hit;
  assign o_miss_evt = accept && in_access && !in_unc && !in_hit;
  assign o_inval_all = accept && (i_req.op == op_invalidate);

  always_comb begin
    if (state_q == s_idle) begin
      o_lookup_idx = in_a.fields.index;
    end else if (flush_q) begin
      o_lookup_idx = walk_q;
    end else begin
      o_lookup_idx = rq_a.fields.index;
    end
  end

  assign o_store_word = (state_q == s_idle) ? in_a.fields.offset[offset_w-1:2] :
                                              rq_a.fields.offset[offset_w-1:2];
  assign o_store_data = (state_q == s_idle) ? i_req.wdata : req_q.wdata;
  assign o_store_strb = (state_q == s_idle) ? i_req.wstrb : req_q.wstrb;
  // write hit, or replay of a write after refill
  assign o_store_wr = (o_hit_evt && |i_req.wstrb) ||
                      (state_q == s_rsp && !flush_q && |req_q.wstrb);

  // write-back targets the resident line, not the request
  assign o_aw_valid = (state_q == s_aw);
  assign o_aw.addr = unc_q ? {req_q.addr[xlen-1:2], 2'b00} :
                             {i_line_tag, o_lookup_idx, {offset_w{1'b0}}};
  assign o_aw.len = unc_q ? '0 : '1;
  assign o_w_valid = (state_q == s_w);
  assign o_w.data = unc_q ? req_q.wdata : i_beat_word;
  assign o_w.strb = unc_q ? req_q.wstrb : '1;
  assign o_w.last = unc_q || (&beat_q);
  assign o_b_ready = (state_q == s_b);
  assign o_ar_valid = (state_q == s_ar);
  assign o_ar.addr = unc_q ? {req_q.addr[xlen-1:2], 2'b00} :
                             {rq_a.fields.tag, rq_a.fields.index, {offset_w{1'b0}}};
  assign o_ar.len = unc_q ? '0 : '1;
  assign o_r_ready = (state_q == s_r);

  assign o_refill_beat = o_r_ready && i_r_valid && !unc_q;
  assign o_refill_data = i_r.data;
  assign o_refill_last = i_r.last;
  assign o_refill_tag = rq_a.fields.tag;
  assign o_clean_line = o_w_valid && i_w_ready && !unc_q;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= s_idle;
      unc_q <= 1'b0;
      flush_q <= 1'b0;
      walk_q <= '0;
      beat_q <= '0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= 1'b0;
      case (state_q)
        s_idle: begin
          if (accept) begin
            unc_q <= in_unc;
            flush_q <= (i_req.op == op_flush);
            walk_q <= '0;
            beat_q <= '0;
            if (i_req.op == op_flush) begin
              state_q <= s_rsp;
            end else if (in_unc) begin
              state_q <= (|i_req.wstrb) ? s_aw : s_ar;
            end else if (in_access && !in_hit) begin
              state_q <= line_wb ? s_aw : s_ar;
            end else begin
              // hit or invalidate answers right away
              o_rsp_valid <= 1'b1;
            end
          end
        end
        s_aw: begin
          if (i_aw_ready) begin
            state_q <= s_w;
          end
        end
        s_w: begin
          if (i_w_ready) begin
            if (!unc_q) begin
              beat_q <= beat_q + 1'b1;
            end
            if (o_w.last) begin
              state_q <= s_b;
            end
          end
        end
        s_b: begin
          if (i_b_valid) begin
            if (unc_q || (flush_q && walk_q == '1)) begin
              o_rsp_valid <= 1'b1;
              state_q <= s_idle;
            end else if (flush_q) begin
              walk_q <= walk_q + 1'b1;
              state_q <= s_rsp;
            end else begin
              state_q <= s_ar;
            end
          end
        end
        s_ar: begin
          if (i_ar_ready) begin
            state_q <= s_r;
          end
        end
        s_r: begin
          if (i_r_valid && i_r.last) begin
            o_rsp_valid <= unc_q;
            state_q <= unc_q ? s_idle : s_rsp;
          end
        end
        s_rsp: begin
          // flush walk step, or replay against the refilled line
          if (!flush_q || (!line_wb && walk_q == '1)) begin
            o_rsp_valid <= 1'b1;
            state_q <= s_idle;
          end else if (line_wb) begin
            state_q <= s_aw;
          end else begin
            walk_q <= walk_q + 1'b1;
          end
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= i_req;
      o_rsp.addr <= i_req.addr;
      o_rsp.rdata <= (in_access && !(|i_req.wstrb)) ? i_line_word : '0;
    end else if (state_q == s_r && unc_q && i_r_valid) begin
      o_rsp.rdata <= i_r.data;
    end else if (state_q == s_rsp && !flush_q && !(|req_q.wstrb)) begin
      o_rsp.rdata <= i_line_word;
    end
  end

endmodule

/* dcache/dcache_line_store.sv */
`timescale 1ns/1ps

module dcache_line_store
  import dcache_pkg::*;
(
  input  logic                     clk,
  input  logic                     nrst,
  input  logic [index_w-1:0]       i_lookup_idx,
  input  logic [$clog2(beats)-1:0] i_word_sel,
  input  logic                     i_store_wr,
  input  logic [xlen-1:0]          i_store_data,
  input  logic [xlen/8-1:0]        i_store_strb,
  input  logic                     i_refill_beat,
  input  logic [xlen-1:0]          i_refill_data,
  input  logic                     i_refill_last,
  input  logic [tag_w-1:0]         i_refill_tag,
  input  logic                     i_clean_line,
  input  logic                     i_inval_all,
  output logic                     o_line_valid,
  output logic                     o_line_dirty,
  output logic [tag_w-1:0]         o_line_tag,
  output logic [xlen-1:0]          o_line_word,
  output logic [xlen-1:0]          o_beat_word
);

  logic [2**index_w-1:0]    valid_q;
  logic [2**index_w-1:0]    dirty_q;
  logic [tag_w-1:0]         tag_q [2**index_w];
  logic [beats*xlen-1:0]    data_q [2**index_w];
  logic [$clog2(beats)-1:0] beat_q;
  logic [xlen-1:0]          merged;

  assign o_line_valid = valid_q[i_lookup_idx];
  assign o_line_dirty = dirty_q[i_lookup_idx];
  assign o_line_tag = tag_q[i_lookup_idx];
  assign o_line_word = data_q[i_lookup_idx][i_word_sel*xlen +: xlen];
  // word under the burst pointer, used as write-back data
  assign o_beat_word = data_q[i_lookup_idx][beat_q*xlen +: xlen];

  always_comb begin
    merged = o_line_word;
    for (int b = 0; b < xlen/8; b++) begin
      if (i_store_strb[b]) begin
        merged[b*8 +: 8] = i_store_data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_q <= '0;
      dirty_q <= '0;
      beat_q <= '0;
    end else if (i_inval_all) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (i_store_wr) begin
        dirty_q[i_lookup_idx] <= 1'b1;
      end
      // each accepted write-back beat cleans and steps the pointer
      if (i_clean_line) begin
        dirty_q[i_lookup_idx] <= 1'b0;
        beat_q <= beat_q + 1'b1;
      end
      if (i_refill_beat) begin
        beat_q <= i_refill_last ? '0 : beat_q + 1'b1;
        if (i_refill_last) begin
          valid_q[i_lookup_idx] <= 1'b1;
          dirty_q[i_lookup_idx] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_store_wr) begin
      data_q[i_lookup_idx][i_word_sel*xlen +: xlen] <= merged;
    end
    if (i_refill_beat) begin
      data_q[i_lookup_idx][beat_q*xlen +: xlen] <= i_refill_data;
      if (i_refill_last) begin
        tag_q[i_lookup_idx] <= i_refill_tag;
      end
    end
  end

endmodule

/* src/dcache_cfg_regs.sv */
`timescale 1ns/1ps

module dcache_cfg_regs
  import dcache_pkg::*;
(
  input  logic            clk,
  input  logic            nrst,
  input  logic            i_cfg_we,
  input  logic [1:0]      i_cfg_addr,
  input  logic [xlen-1:0] i_cfg_wdata,
  output logic [xlen-1:0] o_cfg_rdata,
  input  logic            i_hit_evt,
  input  logic            i_miss_evt,
  output logic [xlen-1:0] o_unc_base,
  output logic [xlen-1:0] o_unc_limit
);

  logic [xlen-1:0] hits_q;
  logic [xlen-1:0] misses_q;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_unc_base <= '0;
      o_unc_limit <= '0;
    end else if (i_cfg_we) begin
      // counters are read only
      if (i_cfg_addr == reg_unc_base) begin
        o_unc_base <= i_cfg_wdata;
      end
      if (i_cfg_addr == reg_unc_limit) begin
        o_unc_limit <= i_cfg_wdata;
      end
    end
  end

  // wrapping event counters
  always_ff @(posedge clk) begin
    if (!nrst) begin
      hits_q <= '0;
      misses_q <= '0;
    end else begin
      if (i_hit_evt) begin
        hits_q <= hits_q + 1'b1;
      end
      if (i_miss_evt) begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_cfg_rdata <= '0;
    end else begin
      case (i_cfg_addr)
        reg_unc_base:  o_cfg_rdata <= o_unc_base;
        reg_unc_limit: o_cfg_rdata <= o_unc_limit;
        reg_hits:      o_cfg_rdata <= hits_q;
        reg_misses:    o_cfg_rdata <= misses_q;
      endcase
    end
  end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic            clk,
  input  logic            nrst,
  input  logic            i_req_valid,
  input  cpu_req_t        i_req,
  output logic            o_req_ready,
  output logic            o_rsp_valid,
  output cpu_rsp_t        o_rsp,
  input  logic            i_cfg_we,
  input  logic [1:0]      i_cfg_addr,
  input  logic [xlen-1:0] i_cfg_wdata,
  output logic [xlen-1:0] o_cfg_rdata,
  output logic            o_aw_valid,
  output axi_aw_t         o_aw,
  input  logic            i_aw_ready,
  output logic            o_w_valid,
  output axi_w_t          o_w,
  input  logic            i_w_ready,
  input  logic            i_b_valid,
  output logic            o_b_ready,
  output logic            o_ar_valid,
  output axi_ar_t         o_ar,
  input  logic            i_ar_ready,
  input  logic            i_r_valid,
  input  axi_r_t          i_r,
  output logic            o_r_ready
);

  logic [xlen-1:0]          unc_base;
  logic [xlen-1:0]          unc_limit;
  logic                     hit_evt;
  logic                     miss_evt;
  logic [index_w-1:0]       lookup_idx;
  logic                     store_wr;
  logic [$clog2(beats)-1:0] store_word;
  logic [xlen-1:0]          store_data;
  logic [xlen/8-1:0]        store_strb;
  logic                     refill_beat;
  logic [xlen-1:0]          refill_data;
  logic                     refill_last;
  logic [tag_w-1:0]         refill_tag;
  logic                     clean_line;
  logic                     inval_all;
  logic                     line_valid;
  logic                     line_dirty;
  logic [tag_w-1:0]         line_tag;
  logic [xlen-1:0]          line_word;
  logic [xlen-1:0]          beat_word;

  // requester and AXI ports share names with the top
  dcache_ctrl i_ctrl (
    .*,
    .i_unc_base(unc_base),
    .i_unc_limit(unc_limit),
    .o_hit_evt(hit_evt),
    .o_miss_evt(miss_evt),
    .o_lookup_idx(lookup_idx),
    .o_store_wr(store_wr),
    .o_store_word(store_word),
    .o_store_data(store_data),
    .o_store_strb(store_strb),
    .o_refill_beat(refill_beat),
    .o_refill_data(refill_data),
    .o_refill_last(refill_last),
    .o_refill_tag(refill_tag),
    .o_clean_line(clean_line),
    .o_inval_all(inval_all),
    .i_line_valid(line_valid),
    .i_line_dirty(line_dirty),
    .i_line_tag(line_tag),
    .i_line_word(line_word),
    .i_beat_word(beat_word)
  );

  dcache_line_store i_line_store (
    .clk(clk),
    .nrst(nrst),
    .i_lookup_idx(lookup_idx),
    .i_word_sel(store_word),
    .i_store_wr(store_wr),
    .i_store_data(store_data),
    .i_store_strb(store_strb),
    .i_refill_beat(refill_beat),
    .i_refill_data(refill_data),
    .i_refill_last(refill_last),
    .i_refill_tag(refill_tag),
    .i_clean_line(clean_line),
    .i_inval_all(inval_all),
    .o_line_valid(line_valid),
    .o_line_dirty(line_dirty),
    .o_line_tag(line_tag),
    .o_line_word(line_word),
    .o_beat_word(beat_word)
  );

  dcache_cfg_regs i_cfg_regs (
    .*,
    .i_hit_evt(hit_evt),
    .i_miss_evt(miss_evt),
    .o_unc_base(unc_base),
    .o_unc_limit(unc_limit)
  );

endmodule

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
  import dcache_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  logic [4:0] i_stall,
  input  logic       i_aw_valid,
  input  axi_aw_t    i_aw,
  output logic       o_aw_ready,
  input  logic       i_w_valid,
  input  axi_w_t     i_w,
  output logic       o_w_ready,
  output logic       o_b_valid,
  input  logic       i_b_ready,
  input  logic       i_ar_valid,
  input  axi_ar_t    i_ar,
  output logic       o_ar_ready,
  output logic       o_r_valid,
  output axi_r_t     o_r,
  input  logic       i_r_ready
);

  // word addressed, 1 KiB
  logic [xlen-1:0] mem [256];
  logic            wr_busy;
  logic            b_pend;
  logic            rd_busy;
  logic [7:0]      wr_ptr;
  logic [7:0]      rd_ptr;
  logic [1:0]      rd_left;

  // stall bits: aw, w, b, ar, r
  assign o_aw_ready = !wr_busy && !b_pend && !o_b_valid && !i_stall[0];
  assign o_w_ready = wr_busy && !i_stall[1];
  assign o_ar_ready = !rd_busy && !i_stall[3];
  assign o_r.data = mem[rd_ptr];
  assign o_r.last = (rd_left == 2'd0);

  always @(posedge clk) begin
    if (!nrst) begin
      wr_busy <= 1'b0;
      b_pend <= 1'b0;
      o_b_valid <= 1'b0;
      rd_busy <= 1'b0;
      o_r_valid <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      rd_left <= '0;
    end else begin
      if (i_aw_valid && o_aw_ready) begin
        wr_busy <= 1'b1;
        wr_ptr <= i_aw.addr[9:2];
      end
      if (i_w_valid && o_w_ready) begin
        for (int b = 0; b < xlen/8; b++) begin
          if (i_w.strb[b]) begin
            mem[wr_ptr][b*8 +: 8] <= i_w.data[b*8 +: 8];
          end
        end
        wr_ptr <= wr_ptr + 1'b1;
        if (i_w.last) begin
          wr_busy <= 1'b0;
          b_pend <= 1'b1;
        end
      end
      if (b_pend && !i_stall[2]) begin
        b_pend <= 1'b0;
        o_b_valid <= 1'b1;
      end
      if (o_b_valid && i_b_ready) begin
        o_b_valid <= 1'b0;
      end
      if (i_ar_valid && o_ar_ready) begin
        rd_busy <= 1'b1;
        rd_ptr <= i_ar.addr[9:2];
        rd_left <= i_ar.len;
      end
      if (o_r_valid && i_r_ready) begin
        o_r_valid <= 1'b0;
        if (rd_left == 2'd0) begin
          rd_busy <= 1'b0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
          rd_left <= rd_left - 1'b1;
        end
      end else if (rd_busy && !o_r_valid && !i_stall[4]) begin
        o_r_valid <= 1'b1;
      end
    end
  end

endmodule

/* verif/dcache_properties.sv */
`timescale 1ns/1ps

module dcache_properties
  import dcache_pkg::*;
(
  input logic    clk,
  input logic    nrst,
  input logic    o_aw_valid,
  input axi_aw_t o_aw,
  input logic    i_aw_ready,
  input logic    o_w_valid,
  input axi_w_t  o_w,
  input logic    i_w_ready,
  input logic    o_ar_valid,
  input axi_ar_t o_ar,
  input logic    i_ar_ready,
  input logic    o_rsp_valid
);

  logic [1:0] burst_len;
  logic [1:0] w_count;

  // beats accepted since the last aw handshake
  always_ff @(posedge clk) begin
    if (!nrst) begin
      burst_len <= '0;
      w_count <= '0;
    end else if (o_aw_valid && i_aw_ready) begin
      burst_len <= o_aw.len;
      w_count <= '0;
    end else if (o_w_valid && i_w_ready) begin
      w_count <= w_count + 1'b1;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw))
    else $error("aw valid or payload changed before its handshake");

  w_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_w_valid && !i_w_ready |=> o_w_valid && $stable(o_w))
    else $error("w valid or payload changed before its handshake");

  ar_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar))
    else $error("ar valid or payload changed before its handshake");

  w_last_beat: assert property (@(posedge clk) disable iff (!nrst)
    o_w_valid |-> (o_w.last == (w_count == burst_len)))
    else $error("w last does not match the burst length");

  rsp_pulse: assert property (@(posedge clk) disable iff (!nrst)
    o_rsp_valid |=> !o_rsp_valid)
    else $error("response valid held for two cycles");

endmodule

/* verif/tb_dcache_top.sv */
`timescale 1ns/1ps

module tb_dcache_top
  import dcache_pkg::*;
();

  localparam int k_req = 0;
  localparam int k_cfg = 1;
  localparam int k_poke = 2;
  localparam int k_count = 3;
  localparam int accept_limit = 200;
  localparam int rsp_limit = 600;

  typedef struct packed {
    logic [1:0]      kind;
    logic [1:0]      op;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;
    logic            chk;
  } step_t;

  logic            clk;
  logic            nrst;
  logic            req_valid;
  cpu_req_t        req;
  logic            req_ready;
  logic            rsp_valid;
  cpu_rsp_t        rsp;
  logic            cfg_we;
  logic [1:0]      cfg_addr;
  logic [xlen-1:0] cfg_wdata;
  logic [xlen-1:0] cfg_rdata;
  logic [4:0]      stall;
  logic            aw_valid;
  logic            aw_ready;
  logic            w_valid;
  logic            w_ready;
  logic            b_valid;
  logic            b_ready;
  logic            ar_valid;
  logic            ar_ready;
  logic            r_valid;
  logic            r_ready;
  axi_aw_t         aw;
  axi_w_t          w;
  axi_ar_t         ar;
  axi_r_t          r;

  // gold holds what reads return and phys the backing memory
  logic [xlen-1:0] gold [256];
  logic [xlen-1:0] phys [256];
  logic [15:0]     rv;
  logic [15:0]     rd;
  logic [tag_w-1:0] rt [16];
  int              hits_exp;
  int              misses_exp;
  logic [xlen-1:0] win_base;
  logic [xlen-1:0] win_limit;
  logic [31:0]     rng;
  step_t           steps[$];
  string           names[$];

  dcache_top i_dcache_top (
    .clk(clk), .nrst(nrst),
    .i_req_valid(req_valid), .i_req(req), .o_req_ready(req_ready),
    .o_rsp_valid(rsp_valid), .o_rsp(rsp),
    .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
    .o_cfg_rdata(cfg_rdata),
    .o_aw_valid(aw_valid), .o_aw(aw), .i_aw_ready(aw_ready),
    .o_w_valid(w_valid), .o_w(w), .i_w_ready(w_ready),
    .i_b_valid(b_valid), .o_b_ready(b_ready),
    .o_ar_valid(ar_valid), .o_ar(ar), .i_ar_ready(ar_ready),
    .i_r_valid(r_valid), .i_r(r), .o_r_ready(r_ready)
  );

  axi_mem_model i_axi_mem (
    .clk(clk), .nrst(nrst), .i_stall(stall),
    .i_aw_valid(aw_valid), .i_aw(aw), .o_aw_ready(aw_ready),
    .i_w_valid(w_valid), .i_w(w), .o_w_ready(w_ready),
    .o_b_valid(b_valid), .i_b_ready(b_ready),
    .i_ar_valid(ar_valid), .i_ar(ar), .o_ar_ready(ar_ready),
    .o_r_valid(r_valid), .o_r(r), .i_r_ready(r_ready)
  );

  bind dcache_top dcache_properties i_props (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // random ready stalls, roughly one in four per channel
  always @(posedge clk) begin
    rng = xorshift(rng);
    stall <= rng[4:0] & rng[12:8];
  end

  task automatic add_step(input string name, input int kind, input logic [1:0] op,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input logic chk);
    steps.push_back({kind[1:0], op, addr, wdata, wstrb, chk});
    names.push_back(name);
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic write_back(input int idx);
    addr_u v;
    int    vb;
    v.raw = '0;
    v.fields.tag = rt[idx];
    v.fields.index = idx;
    vb = v.raw[9:2];
    for (int k = 0; k < beats; k++) begin
      phys[vb+k] = gold[vb+k];
    end
  endtask

  // expected rdata and whether the response comes one edge after acceptance
  task automatic predict(input step_t s, output logic [31:0] exp, output bit quick);
    addr_u a;
    int    idx;
    int    wi;
    int    lb;
    a.raw = s.addr;
    idx = a.fields.index;
    wi = s.addr[9:2];
    lb = {s.addr[9:4], 2'b00};
    exp = '0;
    quick = 1'b0;
    if (s.op == op_flush) begin
      for (int i = 0; i < 16; i++) begin
        if (rv[i] && rd[i]) begin
          write_back(i);
          rd[i] = 1'b0;
        end
      end
    end else if (s.op == op_invalidate) begin
      rv = '0;
      rd = '0;
      for (int k = 0; k < 256; k++) begin
        gold[k] = phys[k];
      end
      quick = 1'b1;
    end else if (s.addr >= win_base && s.addr < win_limit) begin
      if (|s.wstrb) begin
        phys[wi] = merge_bytes(phys[wi], s.wdata, s.wstrb);
        gold[wi] = phys[wi];
      end else begin
        exp = phys[wi];
      end
    end else begin
      if (rv[idx] && rt[idx] == a.fields.tag) begin
        hits_exp++;
        quick = 1'b1;
      end else begin
        misses_exp++;
        if (rv[idx] && rd[idx]) begin
          write_back(idx);
        end
        for (int k = 0; k < beats; k++) begin
          gold[lb+k] = phys[lb+k];
        end
        rv[idx] = 1'b1;
        rd[idx] = 1'b0;
        rt[idx] = a.fields.tag;
      end
      if (|s.wstrb) begin
        gold[wi] = merge_bytes(gold[wi], s.wdata, s.wstrb);
        rd[idx] = 1'b1;
      end else begin
        exp = gold[wi];
      end
    end
  endtask

  task automatic run_request(input cpu_req_t rq, output cpu_rsp_t got, output int edges);
    int n;
    n = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req <= rq;
    @(negedge clk);
    while (!req_ready) begin
      n++;
      if (n > accept_limit) begin
        fail_run("timed out waiting for the cache to accept a request");
      end
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    edges = 0;
    do begin
      @(negedge clk);
      edges++;
      if (edges > rsp_limit) begin
        fail_run("timed out waiting for the cache response");
      end
    end while (!rsp_valid);
    got = rsp;
  endtask

  task automatic cfg_write(input logic [1:0] a, input logic [31:0] d);
    @(posedge clk);
    cfg_we <= 1'b1;
    cfg_addr <= a;
    cfg_wdata <= d;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // readback is registered, one cycle after the address
  task automatic cfg_read(input logic [1:0] a, output logic [31:0] d);
    @(posedge clk);
    cfg_addr <= a;
    @(posedge clk);
    @(negedge clk);
    d = cfg_rdata;
  endtask

  task automatic check_memory(input string name);
    for (int k = 0; k < 256; k++) begin
      check({name, " mem"}, phys[k], i_axi_mem.mem[k]);
    end
  endtask

  initial begin
    step_t       s;
    cpu_req_t    rq;
    cpu_rsp_t    got;
    logic [31:0] exp;
    logic [31:0] val;
    bit          quick;
    int          edges;
    clk = 1'b0;
    nrst = 1'b0;
    req_valid = 1'b0;
    req = '0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    stall = '0;
    rv = '0;
    rd = '0;
    hits_exp = 0;
    misses_exp = 0;
    win_base = '0;
    win_limit = '0;
    rng = 32'h4bfe;
    for (int k = 0; k < 256; k++) begin
      rng = xorshift(rng);
      gold[k] = rng;
      phys[k] = rng;
      i_axi_mem.mem[k] = rng;
    end
    for (int i = 0; i < 16; i++) begin
      rt[i] = '0;
    end

    add_step("rd_miss", k_req, op_access, 32'h024, 0, 4'h0, 0);
    add_step("rd_hit", k_req, op_access, 32'h024, 0, 4'h0, 0);
    add_step("wr_partial", k_req, op_access, 32'h024, 32'ha1b2c3d4, 4'b0101, 1);
    add_step("rd_merged", k_req, op_access, 32'h024, 0, 4'h0, 0);
    add_step("rd_conflict", k_req, op_access, 32'h124, 0, 4'h0, 1);
    add_step("rd_refetch", k_req, op_access, 32'h024, 0, 4'h0, 0);
    add_step("count_before_unc", k_count, op_access, 0, 0, 4'h0, 0);
    add_step("win_base", k_cfg, op_access, reg_unc_base, 32'h300, 4'h0, 0);
    add_step("win_limit", k_cfg, op_access, reg_unc_limit, 32'h380, 4'h0, 0);
    add_step("unc_wr", k_req, op_access, 32'h344, 32'hdeadbeef, 4'hf, 1);
    add_step("unc_rd", k_req, op_access, 32'h344, 0, 4'h0, 0);
    add_step("unc_wr_byte", k_req, op_access, 32'h348, 32'h000000a5, 4'b0001, 1);
    add_step("count_after_unc", k_count, op_access, 0, 0, 4'h0, 0);
    add_step("wr_line5", k_req, op_access, 32'h050, 32'h11223344, 4'hf, 0);
    add_step("wr_line6", k_req, op_access, 32'h064, 32'h55667788, 4'b1100, 0);
    add_step("wr_line7", k_req, op_access, 32'h07c, 32'h99aabbcc, 4'b0011, 0);
    add_step("flush", k_req, op_flush, 0, 0, 4'h0, 1);
    add_step("rd_after_flush5", k_req, op_access, 32'h050, 0, 4'h0, 0);
    add_step("rd_after_flush6", k_req, op_access, 32'h064, 0, 4'h0, 0);
    add_step("poke_mem", k_poke, op_access, 32'h050, 32'h13572468, 4'h0, 0);
    add_step("rd_stale", k_req, op_access, 32'h050, 0, 4'h0, 0);
    add_step("wr_discard", k_req, op_access, 32'h068, 32'hcafef00d, 4'hf, 0);
    add_step("invalidate", k_req, op_invalidate, 0, 0, 4'h0, 1);
    add_step("rd_altered", k_req, op_access, 32'h050, 0, 4'h0, 0);
    add_step("rd_discarded", k_req, op_access, 32'h068, 0, 4'h0, 0);
    add_step("count_final", k_count, op_access, 0, 0, 4'h0, 0);

    repeat (3) @(posedge clk);
    nrst <= 1'b1;
    @(negedge clk);
    check("reset_state", 32'h40,
          {25'd0, req_ready, rsp_valid, aw_valid, w_valid, b_ready, ar_valid, r_ready});

    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      case (s.kind)
        k_req: begin
          predict(s, exp, quick);
          rq.addr = s.addr;
          rq.wdata = s.wdata;
          rq.wstrb = s.wstrb;
          rq.op = s.op;
          run_request(rq, got, edges);
          check(names[i], exp, got.rdata);
          check({names[i], " addr"}, s.addr, got.addr);
          if (quick) begin
            check({names[i], " latency"}, 1, edges);
          end
        end
        k_cfg: begin
          cfg_write(s.addr[1:0], s.wdata);
          if (s.addr[1:0] == reg_unc_base) begin
            win_base = s.wdata;
          end
          if (s.addr[1:0] == reg_unc_limit) begin
            win_limit = s.wdata;
          end
          cfg_read(s.addr[1:0], val);
          check(names[i], s.wdata, val);
        end
        k_poke: begin
          // change memory behind the cache
          @(posedge clk);
          i_axi_mem.mem[s.addr[9:2]] <= s.wdata;
          phys[s.addr[9:2]] = s.wdata;
        end
        default: begin
          cfg_read(reg_hits, val);
          check({names[i], " hits"}, hits_exp, val);
          cfg_read(reg_misses, val);
          check({names[i], " misses"}, misses_exp, val);
        end
      endcase
      if (s.chk) begin
        @(negedge clk);
        check_memory(names[i]);
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
